// File: verilog/cart_hdr_pkg.sv
// Types and constants for the cartridge header region scan
// Imported by the header scanner, the config publisher and the top level
// Region codes double as bit indexes into the header flag vector

package cart_hdr_pkg;

	// One word of the ROM download stream
	typedef logic [15:0] ioctl_data_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// [2] Europe, [1] USA, [0] Japan
	typedef logic [2:0] region_flags_t;

	// Priority order used when the header picks the region
	//   0: US > EU > JP
	//   1: EU > US > JP
	//   2: US > JP > EU
	//   3: JP > US > EU
	typedef logic [1:0] region_prio_t;

	//////////////////////////////////////////////////
	// Header word addresses in the download stream
	//////////////////////////////////////////////////

	localparam int unsigned HDR_REGION_ADDR0 = 'h1F0; // Region chars, both bytes
	localparam int unsigned HDR_REGION_ADDR1 = 'h1F2; // Third region char, low byte
	localparam int unsigned HDR_END_ADDR     = 'h200; // First word past the header

endpackage

// File: verilog/cart_quirk_pkg.sv
// Types and constants for the cartridge ID lookup
// Quirk flags and light-gun settings are produced per known serial
// and handed to the rest of the core after the download

package cart_quirk_pkg;

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] cart_id_t;

	// One bit per compatibility quirk
	typedef logic [5:0] quirk_flags_t;

	// Light-gun sensor delay in pixels
	typedef logic [7:0] gun_delay_t;

	//////////////////////////////////////////////////
	// Quirk bits
	//////////////////////////////////////////////////

	localparam quirk_flags_t QUIRK_SRAM   = 6'b000001; // Forced SRAM mapping
	localparam quirk_flags_t QUIRK_EEPROM = 6'b000010; // Serial EEPROM save
	localparam quirk_flags_t QUIRK_FIFO   = 6'b000100; // Fast VDP FIFO
	localparam quirk_flags_t QUIRK_NORAM  = 6'b001000; // Hide cart RAM
	localparam quirk_flags_t QUIRK_SVP    = 6'b010000; // SVP coprocessor
	localparam quirk_flags_t QUIRK_FMBUSY = 6'b100000; // FM busy flag emulation

	// Delay used for any cartridge without its own entry
	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

	//////////////////////////////////////////////////
	// Serial location in the header
	//////////////////////////////////////////////////

	localparam int unsigned ID_ADDR_FIRST = 'h182; // First word of the serial
	localparam int unsigned ID_ADDR_MATCH = 'h18C; // Lookup happens on this write

endpackage

// File: verilog/header_region_scan.sv
`timescale 1ns/1ps

// Scans the ROM download stream for the region field of the cartridge header
// Flags are cleared when a download starts and updated on each matching write
// hdr_ready marks that the whole header has gone past

module header_region_scan
	import cart_hdr_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              download,
	input  logic              wr,
	input  logic [ADDR_W-1:0] addr,
	input  ioctl_data_t       data,
	output region_flags_t     hdr_flags,
	output logic              hdr_ready
);

	localparam logic [ADDR_W-1:0] A_RGN0 = ADDR_W'(HDR_REGION_ADDR0);
	localparam logic [ADDR_W-1:0] A_RGN1 = ADDR_W'(HDR_REGION_ADDR1);
	localparam logic [ADDR_W-1:0] A_END  = ADDR_W'(HDR_END_ADDR);

	logic          dl_q;
	logic          dl_start;
	logic          hdr_wr;
	region_flags_t flags_nxt;

	// Region letter to its flag, anything else gives none
	function automatic region_flags_t char_flag(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	function automatic logic is_hex(input logic [7:0] c);
		return (c >= "0" && c <= "9") || (c >= "A" && c <= "F");
	endfunction

	// Newer headers code the region as one hex digit
	function automatic region_flags_t hex_flags(input logic [7:0] c);
		logic [3:0] v;
		v = (c >= "A") ? c[3:0] - 4'd7 : c[3:0];
		return {v[3], v[2], v[0]}; // Europe, USA, Japan
	endfunction

	assign dl_start = download & ~dl_q;
	assign hdr_wr   = download & wr;

	always_comb begin
		flags_nxt = dl_start ? '0 : hdr_flags;
		if (hdr_wr && addr == A_RGN0) begin
			if (char_flag(data[7:0]) != '0)
				flags_nxt = flags_nxt | char_flag(data[7:0]);
			else if (is_hex(data[7:0]))
				flags_nxt = hex_flags(data[7:0]); // Digit replaces all flags
			flags_nxt = flags_nxt | char_flag(data[15:8]); // High byte only adds
		end
		if (hdr_wr && addr == A_RGN1)
			flags_nxt = flags_nxt | char_flag(data[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_q      <= download;
			hdr_flags <= flags_nxt;
			if (dl_start)
				hdr_ready <= 1'b0;
			if (hdr_wr && addr == A_END)
				hdr_ready <= 1'b1; // Header fully seen
		end
	end

endmodule

// File: verilog/cart_id_match.sv
`timescale 1ns/1ps

// Collects the 8-character serial from the cartridge header while it streams in
// and looks it up in a small table of known cartridges on the match write
// Gives compatibility quirk flags and light-gun settings for the loaded game

module cart_id_match
	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              download,
	input  logic              wr,
	input  logic [ADDR_W-1:0] addr,
	input  ioctl_data_t       data,
	output quirk_flags_t      quirks,
	output logic              gun_type,
	output gun_delay_t        gun_delay
);

	localparam logic [ADDR_W-1:0] A_ID0   = ADDR_W'(ID_ADDR_FIRST);
	localparam logic [ADDR_W-1:0] A_ID1   = ADDR_W'(ID_ADDR_FIRST + 2);
	localparam logic [ADDR_W-1:0] A_ID2   = ADDR_W'(ID_ADDR_FIRST + 4);
	localparam logic [ADDR_W-1:0] A_ID3   = ADDR_W'(ID_ADDR_FIRST + 6);
	localparam logic [ADDR_W-1:0] A_ID4   = ADDR_W'(ID_ADDR_FIRST + 8);
	localparam logic [ADDR_W-1:0] A_MATCH = ADDR_W'(ID_ADDR_MATCH);

	logic         dl_q;
	logic         dl_start;
	logic         id_wr;
	ioctl_data_t  data_sw;
	cart_id_t     cart_id;
	quirk_flags_t lk_quirks;
	logic         lk_gun_type;
	gun_delay_t   lk_gun_delay;

	assign dl_start = download & ~dl_q;
	assign id_wr    = download & wr;
	assign data_sw  = {data[7:0], data[15:8]}; // Stream words are byte swapped

	//////////////////////////////////////////////////
	// Serial assembly
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (addr)
				A_ID0:   cart_id[63:56] <= data[15:8]; // Only the odd byte belongs to the serial
				A_ID1:   cart_id[55:40] <= data_sw;
				A_ID2:   cart_id[39:24] <= data_sw;
				A_ID3:   cart_id[23:8]  <= data_sw;
				A_ID4:   cart_id[7:0]   <= data[7:0];
				default: ;
			endcase
		end
	end

	// Known cartridge table
	always_comb begin
		lk_quirks    = '0;
		lk_gun_type  = 1'b0;
		lk_gun_delay = GUN_DELAY_DEFAULT;
		case (cart_id)
			"T-081276": lk_quirks = QUIRK_SRAM;
			"T-81406 ": lk_quirks = QUIRK_SRAM;
			"MK-1215 ": lk_quirks = QUIRK_EEPROM;
			"G-4060  ": lk_quirks = QUIRK_EEPROM;
			"T-89016 ": lk_quirks = QUIRK_FIFO;
			"T-113016": lk_quirks = QUIRK_NORAM;  // Game probes for RAM it must not find
			"MK-1229 ": lk_quirks = QUIRK_SVP;
			"G-7001  ": lk_quirks = QUIRK_SVP;
			"T-35036 ": lk_quirks = QUIRK_FMBUSY;
			"MK-1533 ": lk_gun_delay = 8'd100;     // Menacer title
			"T-95096-": begin
				lk_gun_type  = 1'b1;                // Justifier
				lk_gun_delay = 8'd52;
			end
			"T-95136-": begin
				lk_gun_type  = 1'b1;
				lk_gun_delay = 8'd30;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= GUN_DELAY_DEFAULT;
		end else begin
			dl_q <= download;
			if (dl_start) begin
				quirks    <= '0;
				gun_type  <= 1'b0;
				gun_delay <= GUN_DELAY_DEFAULT;
			end
			if (id_wr && addr == A_MATCH) begin
				quirks    <= lk_quirks;
				gun_type  <= lk_gun_type;
				gun_delay <= lk_gun_delay;
			end
		end
	end

endmodule

// File: verilog/cart_config_publish.sv
`timescale 1ns/1ps

// Picks the console region and hands the cartridge config to the core
// Runs once per finished download as requester of a four-phase req/ack handshake
// The config is latched before req rises and held until the handshake completes

module cart_config_publish
	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;
(
	input  logic          clk_sys,
	input  logic          RESET,
	input  logic          download,
	input  region_flags_t hdr_flags,
	input  logic          hdr_ready,
	input  quirk_flags_t  quirks,
	input  logic          gun_type,
	input  gun_delay_t    gun_delay,
	input  logic          auto_region,
	input  region_prio_t  region_prio,
	input  region_t       manual_region,
	input  logic          cfg_ack,
	output logic          cfg_req,
	output region_t       cfg_region,
	output quirk_flags_t  cfg_quirks,
	output logic          cfg_gun_type,
	output gun_delay_t    cfg_gun_delay
);

	typedef enum logic [1:0] {
		IDLE,
		LATCH,
		REQ,
		WAIT_ACK_LOW
	} state_t;

	state_t  state;
	logic    dl_q;
	logic    dl_end;
	region_t region_sel;

	// First flagged region in the chosen order, first of the order if none
	function automatic region_t pick_region(input region_flags_t flags,
		input region_prio_t prio);
		region_t order [3];
		region_t pick;
		case (prio)
			2'd0: order = '{REGION_US, REGION_EU, REGION_JP};
			2'd1: order = '{REGION_EU, REGION_US, REGION_JP};
			2'd2: order = '{REGION_US, REGION_JP, REGION_EU};
			2'd3: order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (flags[order[i]])
				pick = order[i]; // Lower index wins
		end
		return pick;
	endfunction

	assign dl_end = dl_q & ~download;

	always_comb begin
		if (auto_region && hdr_ready)
			region_sel = pick_region(hdr_flags, region_prio);
		else
			region_sel = manual_region; // Disabled or header never completed
	end

	//////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state         <= IDLE;
			dl_q          <= 1'b0;
			cfg_req       <= 1'b0;
			cfg_region    <= REGION_JP;
			cfg_quirks    <= '0;
			cfg_gun_type  <= 1'b0;
			cfg_gun_delay <= GUN_DELAY_DEFAULT;
		end else begin
			dl_q <= download;
			case (state)
				IDLE: if (dl_end) state <= LATCH; // Ends seen mid-handshake are dropped
				LATCH: begin
					cfg_region    <= region_sel;
					cfg_quirks    <= quirks;
					cfg_gun_type  <= gun_type;
					cfg_gun_delay <= gun_delay;
					cfg_req       <= 1'b1;
					state         <= REQ;
				end
				REQ: begin
					if (cfg_ack) begin
						cfg_req <= 1'b0;
						state   <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: if (!cfg_ack) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: verilog/cart_loader.sv
`timescale 1ns/1ps

// Cartridge load inspection top level
// Both scanners watch the same download stream, the publisher combines
// their results at the end of the download and offers them by req/ack

module cart_loader
	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;
#(
	parameter int ADDR_W = 25 // ioctl address width
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              download,
	input  logic              wr,
	input  logic [ADDR_W-1:0] addr,
	input  ioctl_data_t       data,
	input  logic              auto_region,
	input  region_prio_t      region_prio,
	input  region_t           manual_region,
	input  logic              cfg_ack,
	output logic              cfg_req,
	output region_t           cfg_region,
	output quirk_flags_t      cfg_quirks,
	output logic              cfg_gun_type,
	output gun_delay_t        cfg_gun_delay
);

	region_flags_t hdr_flags;
	logic          hdr_ready;
	quirk_flags_t  quirks;
	logic          gun_type;
	gun_delay_t    gun_delay;

	header_region_scan #(.ADDR_W(ADDR_W)) hdr_scan_i (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.download  (download),
		.wr        (wr),
		.addr      (addr),
		.data      (data),
		.hdr_flags (hdr_flags),
		.hdr_ready (hdr_ready)
	);

	cart_id_match #(.ADDR_W(ADDR_W)) id_match_i (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.download  (download),
		.wr        (wr),
		.addr      (addr),
		.data      (data),
		.quirks    (quirks),
		.gun_type  (gun_type),
		.gun_delay (gun_delay)
	);

	cart_config_publish publish_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.download      (download),
		.hdr_flags     (hdr_flags),
		.hdr_ready     (hdr_ready),
		.quirks        (quirks),
		.gun_type      (gun_type),
		.gun_delay     (gun_delay),
		.auto_region   (auto_region),
		.region_prio   (region_prio),
		.manual_region (manual_region),
		.cfg_ack       (cfg_ack),
		.cfg_req       (cfg_req),
		.cfg_region    (cfg_region),
		.cfg_quirks    (cfg_quirks),
		.cfg_gun_type  (cfg_gun_type),
		.cfg_gun_delay (cfg_gun_delay)
	);

endmodule

// File: testbench/cart_loader_props.sv
`timescale 1ns/1ps

// Handshake rules for the cartridge config output
// Bound to the top level, checks the requester side of req/ack

module cart_loader_props
	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;
(
	input logic         clk_sys,
	input logic         RESET,
	input logic         cfg_req,
	input logic         cfg_ack,
	input region_t      cfg_region,
	input quirk_flags_t cfg_quirks,
	input logic         cfg_gun_type,
	input gun_delay_t   cfg_gun_delay
);

	req_hold_a: assert property (@(posedge clk_sys) disable iff (RESET)
		cfg_req && !cfg_ack |=> cfg_req)
		else $error("cfg_req fell before cfg_ack was seen");

	// Whole config frozen while offered
	data_stable_a: assert property (@(posedge clk_sys) disable iff (RESET)
		cfg_req |=> !cfg_req || $stable({cfg_region, cfg_quirks, cfg_gun_type, cfg_gun_delay}))
		else $error("cfg data changed while cfg_req was high");

	no_rise_a: assert property (@(posedge clk_sys) disable iff (RESET)
		!cfg_req && cfg_ack |=> !cfg_req) // Ack must drop first
		else $error("cfg_req rose while cfg_ack was still high");

endmodule

bind cart_loader cart_loader_props props_i (
	.clk_sys       (clk_sys),
	.RESET         (RESET),
	.cfg_req       (cfg_req),
	.cfg_ack       (cfg_ack),
	.cfg_region    (cfg_region),
	.cfg_quirks    (cfg_quirks),
	.cfg_gun_type  (cfg_gun_type),
	.cfg_gun_delay (cfg_gun_delay)
);

// File: testbench/cart_loader_tb.sv
`timescale 1ns/1ps

// Testbench for the cartridge load inspection top level
// Streams a short header for each table entry, then acknowledges the config
// offer after a pseudo-random delay and checks region, quirks and gun settings

module cart_loader_tb
	import cart_hdr_pkg::*;
	import cart_quirk_pkg::*;
();

	localparam int ADDR_W     = 25;
	localparam int CLK_PERIOD = 4;
	localparam int N_ENTRIES  = 10;
	localparam int REQ_WAIT   = 20; // Cycles allowed for one req edge

	typedef struct packed {
		cart_id_t     serial;
		logic [23:0]  rgn;          // Bytes 0x1F0, 0x1F1, 0x1F2
		logic         hdr_done;     // Stream reaches 0x200
		logic         auto_rgn;
		region_prio_t prio;
		region_t      manual;
		region_t      exp_region;
		quirk_flags_t exp_quirks;
		logic         exp_gun_type;
		gun_delay_t   exp_gun_delay;
	} cart_entry_t;

	logic              clk_sys = 1'b0;
	logic              RESET;
	logic              download;
	logic              wr;
	logic [ADDR_W-1:0] addr;
	ioctl_data_t       data;
	logic              auto_region;
	region_prio_t      region_prio;
	region_t           manual_region;
	logic              cfg_ack;
	logic              cfg_req;
	region_t           cfg_region;
	quirk_flags_t      cfg_quirks;
	logic              cfg_gun_type;
	gun_delay_t        cfg_gun_delay;

	cart_entry_t tbl [N_ENTRIES];
	logic [31:0] lfsr;
	int          fails;
	int          tests_failed;

	cart_loader #(.ADDR_W(ADDR_W)) dut_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.download      (download),
		.wr            (wr),
		.addr          (addr),
		.data          (data),
		.auto_region   (auto_region),
		.region_prio   (region_prio),
		.manual_region (manual_region),
		.cfg_ack       (cfg_ack),
		.cfg_req       (cfg_req),
		.cfg_region    (cfg_region),
		.cfg_quirks    (cfg_quirks),
		.cfg_gun_type  (cfg_gun_type),
		.cfg_gun_delay (cfg_gun_delay)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Cartridge table
	//////////////////////////////////////////////////

	// serial, region bytes, header done, auto, prio, manual,
	// then expected region, quirks, gun type, gun delay
	task automatic load_table();
		tbl[0] = '{"T-081276", "JUE", 1'b1, 1'b1, 2'd0, REGION_JP, REGION_US, 6'h01, 1'b0, 8'd44};
		tbl[1] = '{"MK-1215 ", "J U", 1'b1, 1'b1, 2'd1, REGION_EU, REGION_US, 6'h02, 1'b0, 8'd44};
		tbl[2] = '{"T-89016 ", "EU ", 1'b1, 1'b1, 2'd2, REGION_JP, REGION_US, 6'h04, 1'b0, 8'd44};
		tbl[3] = '{"MK-1229 ", "   ", 1'b1, 1'b1, 2'd1, REGION_JP, REGION_EU, 6'h10, 1'b0, 8'd44};
		tbl[4] = '{"T-113016", "4  ", 1'b1, 1'b1, 2'd3, REGION_EU, REGION_US, 6'h08, 1'b0, 8'd44};
		tbl[5] = '{"T-35036 ", "A  ", 1'b1, 1'b1, 2'd0, REGION_JP, REGION_EU, 6'h20, 1'b0, 8'd44};
		tbl[6] = '{"MK-1533 ", "JUE", 1'b1, 1'b0, 2'd0, REGION_EU, REGION_EU, 6'h00, 1'b0, 8'd100};
		tbl[7] = '{"T-95096-", "U  ", 1'b0, 1'b1, 2'd0, REGION_EU, REGION_EU, 6'h00, 1'b1, 8'd52};
		tbl[8] = '{"XYZ-0000", "8J ", 1'b1, 1'b1, 2'd3, REGION_US, REGION_JP, 6'h00, 1'b0, 8'd44};
		tbl[9] = '{"T-81406 ", "E J", 1'b1, 1'b1, 2'd2, REGION_US, REGION_JP, 6'h01, 1'b0, 8'd44};
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// ROM image byte, serial at 0x183..0x18A, words little endian
	function automatic logic [7:0] header_byte(input cart_entry_t e, input int b);
		logic [7:0] v;
		v = 8'(b) ^ 8'(b >> 8); // Filler
		if (b >= 'h183 && b <= 'h18A)
			v = 8'(e.serial >> (8 * ('h18A - b)));
		else if (b == 'h1F0)
			v = e.rgn[23:16];
		else if (b == 'h1F1)
			v = e.rgn[15:8];
		else if (b == 'h1F2)
			v = e.rgn[7:0];
		return v;
	endfunction

	function automatic logic [16:0] cfg_word();
		return {cfg_region, cfg_quirks, cfg_gun_type, cfg_gun_delay};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			fails++;
		end
	endtask

	task automatic write_word(input int a, input cart_entry_t e);
		@(posedge clk_sys);
		wr   <= 1'b1;
		addr <= ADDR_W'(a);
		data <= {header_byte(e, a + 1), header_byte(e, a)};
	endtask

	task automatic check_reset();
		int fails0;
		fails0 = fails;
		@(negedge clk_sys);
		check_value("cfg_req", 64'(cfg_req), 64'd0);
		check_value("cfg_region", 64'(cfg_region), 64'd0);
		check_value("cfg_quirks", 64'(cfg_quirks), 64'd0);
		check_value("cfg_gun_type", 64'(cfg_gun_type), 64'd0);
		check_value("cfg_gun_delay", 64'(cfg_gun_delay), 64'd44);
		check_value("hdr_ready", 64'(dut_i.hdr_ready), 64'd0);
		if (fails != fails0) begin
			tests_failed++;
			$display("reset values: FAIL");
		end else begin
			$display("reset values: ok");
		end
	endtask

	//////////////////////////////////////////////////
	// One download and its handshake
	//////////////////////////////////////////////////

	task automatic run_entry(input int idx);
		cart_entry_t e;
		int          fails0;
		int          wait_n;
		logic [2:0]  ack_dly;
		logic [16:0] snap;
		e       = tbl[idx];
		fails0  = fails;
		ack_dly = 3'd0;
		@(posedge clk_sys);
		download      <= 1'b1;
		auto_region   <= e.auto_rgn;
		region_prio   <= e.prio;
		manual_region <= e.manual;
		for (int w = 0; w < 7; w++)
			write_word('h180 + 2 * w, e); // Serial words up to the match word
		write_word('h1F0, e);
		write_word('h1F2, e);
		if (e.hdr_done)
			write_word('h200, e);
		@(posedge clk_sys);
		wr <= 1'b0;
		@(posedge clk_sys);
		download <= 1'b0;

		// Edges from the drop of download to req
		wait_n = 0;
		@(negedge clk_sys);
		while (!cfg_req && wait_n < REQ_WAIT) begin
			@(negedge clk_sys);
			wait_n++;
		end
		if (!cfg_req) begin
			$display("entry %0d: cfg_req did not rise after the download ended", idx);
			fails++;
		end else begin
			check_value("cfg_req latency", 64'(wait_n), 64'd2);
			check_value("cfg_region", 64'(cfg_region), 64'(e.exp_region));
			check_value("cfg_quirks", 64'(cfg_quirks), 64'(e.exp_quirks));
			check_value("cfg_gun_type", 64'(cfg_gun_type), 64'(e.exp_gun_type));
			check_value("cfg_gun_delay", 64'(cfg_gun_delay), 64'(e.exp_gun_delay));
			snap = cfg_word();
			for (int k = 0; k < 3; k++) begin
				lfsr    = lfsr_next(lfsr);
				ack_dly = {ack_dly[1:0], lfsr[0]};
			end
			repeat (ack_dly) begin
				@(negedge clk_sys);
				check_value("cfg_req", 64'(cfg_req), 64'd1);
				check_value("cfg data", 64'(cfg_word()), 64'(snap));
			end
			@(posedge clk_sys);
			cfg_ack <= 1'b1;
			wait_n = 0;
			do begin
				@(negedge clk_sys);
				if (cfg_req)
					check_value("cfg data", 64'(cfg_word()), 64'(snap));
				wait_n++;
			end while (cfg_req && wait_n < REQ_WAIT);
			if (cfg_req) begin
				$display("entry %0d: cfg_req stayed high after cfg_ack", idx);
				fails++;
			end
			@(posedge clk_sys);
			cfg_ack <= 1'b0;
			@(negedge clk_sys);
			check_value("cfg_req", 64'(cfg_req), 64'd0);
		end
		if (fails != fails0) begin
			tests_failed++;
			$display("entry %0d serial %s ack delay %0d: FAIL", idx, e.serial, ack_dly);
		end else begin
			$display("entry %0d serial %s ack delay %0d: ok", idx, e.serial, ack_dly);
		end
	endtask

	initial begin
		RESET         = 1'b1;
		download      = 1'b0;
		wr            = 1'b0;
		addr          = '0;
		data          = '0;
		auto_region   = 1'b0;
		region_prio   = 2'd0;
		manual_region = REGION_JP;
		cfg_ack       = 1'b0;
		lfsr          = 32'h1562_cd42;
		fails         = 0;
		tests_failed  = 0;
		load_table();
		repeat (4) @(posedge clk_sys);
		RESET <= 1'b0;
		check_reset();
		for (int i = 0; i < N_ENTRIES; i++)
			run_entry(i);
		$display("Summary: %0d run, %0d passed, %0d failed", N_ENTRIES + 1,
			N_ENTRIES + 1 - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		#(N_ENTRIES * 200 * CLK_PERIOD);
		$display("Watchdog expired before all entries finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: sources.f
verilog/cart_hdr_pkg.sv
verilog/cart_quirk_pkg.sv
verilog/header_region_scan.sv
verilog/cart_id_match.sv
verilog/cart_config_publish.sv
verilog/cart_loader.sv
testbench/cart_loader_props.sv
testbench/cart_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cart loader testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module cart_loader_tb \
	-f sources.f \
	--Mdir obj_dir

out=$(./obj_dir/Vcart_loader_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
